// ==== filelist.f ====
+incdir+include
design/bp_pkg.sv
design/btb.sv
design/bht.sv
design/branch_predictor.sv
design/resolve_unit.sv
design/fetch_pc.sv
design/bp_top.sv
sim/bp_asserts.sv
sim/bp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert --timescale 1ns/100ps \
      --top-module bp_tb -f filelist.f -Mdir obj_dir; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vbp_tb > "$log" 2>&1
run_status=$?
cat "$log"

if [ "$run_status" -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Done: no errors" "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== sim/bp_tb.sv ====
`include "bp_config.svh"

module bp_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import bp_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 10;
   localparam int ACK_LIMIT = 16;

   // cycle budget per test
   localparam int WALK_CYCLES = 8 + 3 + 6 + 4;
   localparam int NUM_RESOLVES = 12;
   localparam int RESOLVE_CYCLES = 6;
   localparam int BUDGET_CYCLES = RESET_CYCLES + WALK_CYCLES + NUM_RESOLVES * RESOLVE_CYCLES;
   localparam int WATCHDOG_NS = BUDGET_CYCLES * CLK_PERIOD * 2;

   // branch under test, index 5, and its taken target
   localparam logic [31:0] P_ADDR = 32'h0000_2014;
   localparam logic [31:0] T_ADDR = 32'h0000_3400;

   logic     clk;
   logic     reset;
   logic     fetch_ready;
   fetch_t   fetch;
   logic     resolve_req;
   resolve_t resolve;
   logic     resolve_ack;

   int checks;
   int errors;

   // reference tables and expected fetch pc
   logic                    m_valid [`BP_ENTRIES];
   logic [`BP_TAG_BITS-1:0] m_tag [`BP_ENTRIES];
   logic [31:0]             m_tgt [`BP_ENTRIES];
   int                      m_ctr [`BP_ENTRIES];
   logic [31:0]             exp_pc;

   bp_top uut (
      .clk         (clk),
      .reset       (reset),
      .fetch_ready (fetch_ready),
      .fetch       (fetch),
      .resolve_req (resolve_req),
      .resolve     (resolve),
      .resolve_ack (resolve_ack)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // taken needs a valid tag match and a counter of 2 or more
   function automatic logic model_taken(input logic [31:0] addr);
      pc_u p;
      p.addr = addr;
      return m_valid[p.f.index] && (m_tag[p.f.index] == p.f.tag) && (m_ctr[p.f.index] >= 2);
   endfunction

   function automatic logic [31:0] model_target(input logic [31:0] addr);
      pc_u p;
      p.addr = addr;
      if (model_taken(addr)) begin
         return m_tgt[p.f.index];
      end
      return addr + 32'd4;
   endfunction

   // table training, plus the redirect it causes with fetch stalled
   task automatic model_resolve(input resolve_t rec);
      int          idx;
      logic [31:0] actual;
      idx = rec.branch_pc.f.index;
      actual = rec.taken ? rec.target : rec.branch_pc.addr + 32'd4;
      if (rec.taken) begin
         m_valid[idx] = 1'b1;
         m_tag[idx] = rec.branch_pc.f.tag;
         m_tgt[idx] = rec.target;
         if (m_ctr[idx] < 3) m_ctr[idx]++;
      end else if (m_ctr[idx] > 0) begin
         m_ctr[idx]--;
      end
      if (rec.taken != rec.pred_taken || actual != rec.pred_target) begin
         exp_pc = actual;
      end
   endtask

   task automatic check_fetch(input string name);
      logic        exp_taken;
      logic [31:0] exp_target;
      exp_taken = model_taken(exp_pc);
      exp_target = model_target(exp_pc);
      checks++;
      assert (fetch.pc == exp_pc) else begin
         $display("FAIL %s pc: expected %h, actual %h", name, exp_pc, fetch.pc);
         errors++;
      end
      assert (fetch.pred_taken == exp_taken) else begin
         $display("FAIL %s pred_taken: expected %b, actual %b", name, exp_taken,
                  fetch.pred_taken);
         errors++;
      end
      assert (fetch.pred_target == exp_target) else begin
         $display("FAIL %s pred_target: expected %h, actual %h", name, exp_target,
                  fetch.pred_target);
         errors++;
      end
   endtask

   // fetch running, pc follows the prediction
   task automatic walk(input string name, input int n);
      for (int i = 0; i < n; i++) begin
         check_fetch(name);
         exp_pc = model_target(exp_pc);
         @(negedge clk);
      end
   endtask

   // fetch stalled, pc must not move
   task automatic hold_check(input string name, input int n);
      for (int i = 0; i < n; i++) begin
         check_fetch(name);
         @(negedge clk);
      end
   endtask

   function automatic resolve_t make_rec(input logic [31:0] addr, input logic taken,
                                         input logic [31:0] target, input logic pt,
                                         input logic [31:0] ptgt);
      resolve_t r;
      r.branch_pc.addr = addr;
      r.taken = taken;
      r.target = target;
      r.pred_taken = pt;
      r.pred_target = ptgt;
      return r;
   endfunction

   // four-phase handshake, fetch checked on the edge after ack rises
   task automatic do_resolve(input resolve_t rec, input string name);
      int waited;
      @(posedge clk);
      resolve <= rec;
      resolve_req <= 1'b1;
      model_resolve(rec);
      waited = 0;
      @(negedge clk);
      while (!resolve_ack && waited < ACK_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!resolve_ack) begin
         $display("%s: ack never rose for branch at %h", name, rec.branch_pc.addr);
         errors++;
      end
      @(posedge clk);
      resolve_req <= 1'b0;
      @(negedge clk);
      check_fetch(name);
      waited = 0;
      while (resolve_ack && waited < ACK_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (resolve_ack) begin
         $display("%s: ack stayed high after req dropped", name);
         errors++;
      end
   endtask

   // redirect via a not-taken branch just before dest that was predicted taken
   task automatic steer(input logic [31:0] dest, input string name);
      do_resolve(make_rec(dest - 32'd4, 1'b0, 32'h0, 1'b1, dest), name);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog: run exceeded %0d ns", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      logic [31:0] rnd;
      logic [31:0] alias_pc;
      void'($urandom(32'h7bcb9f9a));
      checks = 0;
      errors = 0;
      reset <= 1'b1;
      fetch_ready <= 1'b0;
      resolve_req <= 1'b0;
      resolve <= '0;
      for (int i = 0; i < `BP_ENTRIES; i++) begin
         m_valid[i] = 1'b0;
         m_tag[i] = '0;
         m_tgt[i] = '0;
         m_ctr[i] = 3;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      fetch_ready <= 1'b1;
      exp_pc = `BP_BOOT_PC;
      @(negedge clk);
      walk("boot_walk", 8);

      // back-pressure
      @(posedge clk);
      fetch_ready <= 1'b0;
      exp_pc = model_target(exp_pc);
      @(negedge clk);
      hold_check("stall_hold", 3);

      // first taken resolve allocates, counter already 3
      do_resolve(make_rec(P_ADDR, 1'b1, T_ADDR, 1'b0, P_ADDR + 32'd4), "taken_redirect");
      steer(P_ADDR, "taken_hit");

      // 3 -> 2 -> 1, then back up to 2
      do_resolve(make_rec(P_ADDR, 1'b0, T_ADDR, 1'b1, T_ADDR), "not_taken_redirect");
      do_resolve(make_rec(P_ADDR, 1'b0, T_ADDR, 1'b0, P_ADDR + 32'd4), "no_redirect_hold");
      steer(P_ADDR, "weak_not_taken");
      do_resolve(make_rec(P_ADDR, 1'b1, T_ADDR, 1'b0, P_ADDR + 32'd4), "retrain_redirect");
      steer(P_ADDR, "weak_taken");

      // same index, other tag
      for (int i = 0; i < 4; i++) begin
         rnd = $urandom();
         alias_pc = {rnd[31:7], P_ADDR[6:0]};
         if (alias_pc[31:7] == P_ADDR[31:7]) begin
            alias_pc[31] = ~alias_pc[31];
         end
         steer(alias_pc, "alias_miss");
         hold_check("alias_hold", 1);
      end

      // run through the predicted branch
      steer(P_ADDR, "final_steer");
      @(posedge clk);
      fetch_ready <= 1'b1;
      @(negedge clk);
      walk("taken_walk", 6);

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== sim/bp_asserts.sv ====
module bp_asserts (
   input logic clk,
   input logic reset,
   input logic req,
   input logic ack,
   input logic btb_en,
   input logic bht_en,
   input logic redirect
);

   timeunit 1ns;
   timeprecision 100ps;

   // ack answers a req seen at the previous edge
   ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req))
      else $error("ack rose with no req pending");

   // one-cycle table strobes
   btb_strobe_once: assert property (@(posedge clk) disable iff (reset)
      btb_en |=> !btb_en)
      else $error("btb write enable held for more than one cycle");

   bht_strobe_once: assert property (@(posedge clk) disable iff (reset)
      bht_en |=> !bht_en)
      else $error("bht update enable held for more than one cycle");

   // ack only drops once req is low
   ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> !$past(req))
      else $error("ack fell while req was still high");

   // mispredict comes with the update
   redirect_with_strobe: assert property (@(posedge clk) disable iff (reset)
      redirect |-> bht_en)
      else $error("redirect without a table update");

endmodule

bind resolve_unit bp_asserts u_bp_asserts (
   .clk      (clk),
   .reset    (reset),
   .req      (req),
   .ack      (ack),
   .btb_en   (btb_wr.en),
   .bht_en   (bht_upd.en),
   .redirect (redirect)
);

// ==== design/bp_top.sv ====
module bp_top (
   input  logic            clk,
   input  logic            reset,
   input  logic            fetch_ready,
   output bp_pkg::fetch_t   fetch,
   input  logic            resolve_req,
   input  bp_pkg::resolve_t resolve,
   output logic            resolve_ack
);

   import bp_pkg::*;

   // fetch side
   pc_u         pc;
   logic        pred_taken;
   logic [31:0] pred_target;

   // table read results
   logic        btb_hit;
   logic [31:0] btb_target;
   logic        bht_taken;

   // resolve side
   btb_write_t  btb_wr;
   bht_update_t bht_upd;
   logic        redirect;
   logic [31:0] redirect_pc;

   fetch_pc u_fetch_pc (
      .clk         (clk),
      .reset       (reset),
      .ready       (fetch_ready),
      .pred_target (pred_target),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .pc          (pc)
   );

   branch_predictor u_branch_predictor (
      .pc          (pc),
      .pred_taken  (pred_taken),
      .pred_target (pred_target),
      .btb_hit     (btb_hit),
      .btb_target  (btb_target),
      .bht_taken   (bht_taken)
   );

   btb u_btb (
      .clk       (clk),
      .reset     (reset),
      .lookup_pc (pc),
      .hit       (btb_hit),
      .target    (btb_target),
      .wr        (btb_wr)
   );

   // counters share the btb index
   bht u_bht (
      .clk           (clk),
      .reset         (reset),
      .index         (pc.f.index),
      .predict_taken (bht_taken),
      .upd           (bht_upd)
   );

   resolve_unit u_resolve_unit (
      .clk         (clk),
      .reset       (reset),
      .req         (resolve_req),
      .ack         (resolve_ack),
      .res         (resolve),
      .btb_wr      (btb_wr),
      .bht_upd     (bht_upd),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   assign fetch.pc          = pc.addr;
   assign fetch.pred_taken  = pred_taken;
   assign fetch.pred_target = pred_target;

endmodule

// ==== design/fetch_pc.sv ====
`include "bp_config.svh"

module fetch_pc (
   input  logic        clk,
   input  logic        reset,
   input  logic        ready,
   input  logic [31:0] pred_target,
   input  logic        redirect,
   input  logic [31:0] redirect_pc,
   output bp_pkg::pc_u  pc
);

   import bp_pkg::*;

   pc_u pc_next;

   // redirect wins over back-pressure
   // a mispredict must not wait for fetch to drain
   always_comb begin
      if (redirect) begin
         pc_next.addr = redirect_pc;
      end else if (ready) begin
         pc_next.addr = pred_target;
      end else begin
         // stalled, hold the current fetch
         pc_next = pc;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc.addr <= `BP_BOOT_PC;
      end else begin
         pc <= pc_next;
      end
   end

endmodule

// ==== design/resolve_unit.sv ====
module resolve_unit (
   input  logic               clk,
   input  logic               reset,
   input  logic               req,
   output logic               ack,
   input  bp_pkg::resolve_t    res,
   output bp_pkg::btb_write_t  btb_wr,
   output bp_pkg::bht_update_t bht_upd,
   output logic               redirect,
   output logic [31:0]        redirect_pc
);

   import bp_pkg::*;

   // idle -> strobe (one cycle, ack up) -> wait_low (ack up until req drops)
   typedef enum logic [1:0] {
      IDLE,
      STROBE,
      WAIT_LOW
   } state_t;

   state_t state;

   // record captured at the req edge
   resolve_t res_q;

   // outcome of the captured branch
   logic [31:0] actual_next;
   logic        mispredict;
   logic        strobe;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (req) begin
                  state <= STROBE;
               end
            end
            // req may already be gone by the end of the strobe cycle
            STROBE: begin
               state <= req ? WAIT_LOW : IDLE;
            end
            WAIT_LOW: begin
               if (!req) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // payload only, held stable by execute while req is up
   always_ff @(posedge clk) begin
      if (state == IDLE && req) begin
         res_q <= res;
      end
   end

   assign strobe = (state == STROBE);
   assign ack    = (state != IDLE);

   // not taken falls through to the next word
   always_comb begin
      actual_next = res_q.taken ? res_q.target : res_q.branch_pc.addr + 32'd4;
      mispredict  = (res_q.taken != res_q.pred_taken) ||
                    (actual_next != res_q.pred_target);
   end

   // only taken branches allocate in the btb
   assign btb_wr.en     = strobe && res_q.taken;
   assign btb_wr.index  = res_q.branch_pc.f.index;
   assign btb_wr.tag    = res_q.branch_pc.f.tag;
   assign btb_wr.target = res_q.target;

   // every branch trains its counter
   assign bht_upd.en    = strobe;
   assign bht_upd.index = res_q.branch_pc.f.index;
   assign bht_upd.taken = res_q.taken;

   // redirect lines up with the table strobes
   assign redirect    = strobe && mispredict;
   assign redirect_pc = actual_next;

endmodule

// ==== design/branch_predictor.sv ====
module branch_predictor (
   input  bp_pkg::pc_u  pc,
   output logic        pred_taken,
   output logic [31:0] pred_target,
   input  logic        btb_hit,
   input  logic [31:0] btb_target,
   input  logic        bht_taken
);

   // sequential fall-through
   logic [31:0] seq_pc;

   assign seq_pc = pc.addr + 32'd4;

   // need both a known target and a taken counter
   // a hit with a weak counter still falls through
   always_comb begin
      pred_taken = btb_hit && bht_taken;
      if (pred_taken) begin
         pred_target = btb_target;
      end else begin
         pred_target = seq_pc;
      end
   end

endmodule

// ==== design/bht.sv ====
`include "bp_config.svh"

module bht (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [`BP_INDEX_BITS-1:0] index,
   output logic                      predict_taken,
   input  bp_pkg::bht_update_t        upd
);

   localparam logic [`BP_CTR_BITS-1:0] CTR_MAX = '1;
   localparam logic [`BP_CTR_BITS-1:0] CTR_MIN = '0;

   logic [`BP_CTR_BITS-1:0] ctr [`BP_ENTRIES];

   // counter being updated
   logic [`BP_CTR_BITS-1:0] cur;

   assign cur = ctr[upd.index];

   // msb of the counter is the direction
   // 2 and 3 mean taken
   assign predict_taken = ctr[index][`BP_CTR_BITS-1];

   always_ff @(posedge clk) begin
      if (reset) begin
         // start every entry strongly taken
         for (int i = 0; i < `BP_ENTRIES; i++) begin
            ctr[i] <= CTR_MAX;
         end
      end else if (upd.en) begin
         if (upd.taken) begin
            // saturate at 3
            if (cur != CTR_MAX) begin
               ctr[upd.index] <= cur + 1'b1;
            end
         end else begin
            // saturate at 0
            if (cur != CTR_MIN) begin
               ctr[upd.index] <= cur - 1'b1;
            end
         end
      end
   end

endmodule

// ==== design/btb.sv ====
`include "bp_config.svh"

module btb (
   input  logic              clk,
   input  logic              reset,
   input  bp_pkg::pc_u        lookup_pc,
   output logic              hit,
   output logic [31:0]       target,
   input  bp_pkg::btb_write_t wr
);

   // per-entry storage
   logic [`BP_TAG_BITS-1:0] tag_mem [`BP_ENTRIES];
   logic [31:0]             tgt_mem [`BP_ENTRIES];
   logic [`BP_ENTRIES-1:0]  valid;

   // lookup side
   logic [`BP_INDEX_BITS-1:0] rd_idx;
   logic [`BP_TAG_BITS-1:0]   rd_tag;
   logic                      tag_match;

   assign rd_idx = lookup_pc.f.index;
   assign rd_tag = lookup_pc.f.tag;

   // combinational read, same cycle as the pc
   always_comb begin
      tag_match = (tag_mem[rd_idx] == rd_tag);
      hit       = valid[rd_idx] && tag_match;
      target    = tgt_mem[rd_idx];
   end

   // valid bits
   // an empty entry never hits, whatever is left in tag_mem
   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= '0;
      end else if (wr.en) begin
         valid[wr.index] <= 1'b1;
      end
   end

   // tag and target arrays
   // plain write port, overwrite on every taken resolve
   always_ff @(posedge clk) begin
      if (wr.en) begin
         tag_mem[wr.index] <= wr.tag;
         tgt_mem[wr.index] <= wr.target;
      end
   end

endmodule

// ==== design/bp_pkg.sv ====
`include "bp_config.svh"

package bp_pkg;

   // pc split for table access
   // word aligned, so the low two bits are the byte offset
   typedef struct packed {
      logic [`BP_TAG_BITS-1:0]   tag;
      logic [`BP_INDEX_BITS-1:0] index;
      logic [1:0]                offset;
   } pc_fields_t;

   // same 32-bit word, either a plain address or tag/index/offset
   typedef union packed {
      logic [31:0] addr;
      pc_fields_t  f;
   } pc_u;

   // current fetch and what the predictor said about it
   typedef struct packed {
      logic [31:0] pc;
      logic        pred_taken;
      logic [31:0] pred_target;
   } fetch_t;

   // resolved branch from execute
   // pred_* is the earlier prediction carried down the pipe
   typedef struct packed {
      pc_u         branch_pc;
      logic        taken;
      logic [31:0] target;
      logic        pred_taken;
      logic [31:0] pred_target;
   } resolve_t;

   // btb entry write
   typedef struct packed {
      logic                      en;
      logic [`BP_INDEX_BITS-1:0] index;
      logic [`BP_TAG_BITS-1:0]   tag;
      logic [31:0]               target;
   } btb_write_t;

   // direction counter update, one step per resolved branch
   typedef struct packed {
      logic                      en;
      logic [`BP_INDEX_BITS-1:0] index;
      logic                      taken;
   } bht_update_t;

endpackage

// ==== include/bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// table index from pc[6:2]
`define BP_INDEX_BITS 5
`define BP_ENTRIES 32

// tag from pc[31:7]
`define BP_TAG_BITS 25

// 2-bit saturating direction counters
`define BP_CTR_BITS 2

// first fetch address out of reset
`define BP_BOOT_PC 32'h0000_1000

`endif
